// ==== common/memStagePkg.sv ====
package memStagePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int cacheLines = 64;
    localparam int indexBits = 6;
    // word lines, so two offset bits below the index
    localparam int tagBits = 32 - indexBits - 2;
    // kseg1 style window, never cached
    localparam logic [2:0] uncachedSeg = 3'b101;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        opNone,
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opLwl,
        opLwr,
        opSb,
        opSh,
        opSw,
        opSwl
    } memOpE;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [31:0] pc;
        memOpE       op;
        // alu result, address or pass-through data
        logic [31:0] addr;
        logic [31:0] storeData;
        logic [4:0]  rtId;
        logic        regWe;
        logic [4:0]  regNum;
        logic [3:0]  t;
    } exStageS;

    typedef struct packed {
        logic        regWe;
        logic [3:0]  regWeBytes;
        logic [4:0]  regId;
        logic [31:0] data;
        logic [31:0] pc;
        logic [3:0]  t;
    } memStageS;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage to cache, cache to bus master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } cacheReqS;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } busReqS;

    // wishbone classic
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] datW;
        logic [3:0]  sel;
    } wbOutS;

    typedef struct packed {
        logic [31:0] datR;
        logic        ack;
    } wbInS;

endpackage

// ==== memStage/loadAligner.sv ====
module loadAligner (
    input  memStagePkg::memOpE op,
    input  logic [1:0]         offset,
    input  logic [31:0]        rawData,
    input  logic [31:0]        passData,
    input  logic               regWe,
    output logic [31:0]        data,
    output logic [3:0]         regWeBytes
);
    import memStagePkg::*;

    logic [4:0]  laneShift;
    logic [31:0] shiftedR;
    logic [31:0] shiftedL;
    logic [3:0]  weAll;

    assign laneShift = {offset, 3'b000};
    assign shiftedR = rawData >> laneShift;
    assign shiftedL = rawData << laneShift;
    // all enables drop out when the instruction writes no register
    assign weAll = {4{regWe}};

    always_comb begin
        data = passData;
        regWeBytes = weAll;
        unique case (op)
            opLb: begin
                data = {{24{shiftedR[7]}}, shiftedR[7:0]};
            end
            opLbu: begin
                data = {24'h000000, shiftedR[7:0]};
            end
            opLh: begin
                data = {{16{shiftedR[15]}}, shiftedR[15:0]};
            end
            opLhu: begin
                data = {16'h0000, shiftedR[15:0]};
            end
            opLw: begin
                data = rawData;
            end
            // partial word, the writeback merges by byte enable
            opLwl: begin
                data = shiftedL;
                regWeBytes = weAll << (2'd3 - offset);
            end
            opLwr: begin
                data = shiftedR;
                regWeBytes = weAll >> offset;
            end
            default: begin
                data = passData;
            end
        endcase
    end

endmodule

// ==== memStage/memStage.sv ====
module memStage (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    flush,
    input  memStagePkg::exStageS    exStage,
    output memStagePkg::cacheReqS   cacheReq,
    input  logic                    cacheReady,
    input  logic [31:0]             cacheRdata,
    output logic                    memStall,
    output memStagePkg::memStageS   memOut
);
    import memStagePkg::*;

    logic        isLoad;
    logic        isStore;
    logic [1:0]  offset;
    logic [4:0]  laneShift;
    logic [31:0] rtValue;
    logic [31:0] storeWord;
    logic [3:0]  storeSel;
    logic [31:0] alignedData;
    logic [3:0]  alignedWe;
    logic [3:0]  tNext;

    assign offset = exStage.addr[1:0];
    assign laneShift = {offset, 3'b000};

    assign isLoad = exStage.op inside {opLb, opLbu, opLh, opLhu, opLw, opLwl, opLwr};
    assign isStore = exStage.op inside {opSb, opSh, opSw, opSwl};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store data path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // own result from last cycle, not yet in the register file
    assign rtValue = (memOut.regWe && exStage.rtId != 5'd0 &&
                      exStage.rtId == memOut.regId) ? memOut.data : exStage.storeData;

    always_comb begin
        storeWord = rtValue;
        storeSel = 4'b1111;
        unique case (exStage.op)
            opSb: begin
                storeWord = rtValue << laneShift;
                storeSel = 4'b0001 << offset;
            end
            opSh: begin
                storeWord = rtValue << laneShift;
                storeSel = 4'b0011 << offset;
            end
            opSw: begin
                storeWord = rtValue;
                storeSel = 4'b1111;
            end
            // upper bytes of rt land in lanes 0..offset
            opSwl: begin
                storeWord = rtValue >> {2'd3 - offset, 3'b000};
                storeSel = 4'b1111 >> (2'd3 - offset);
            end
            default: begin
                storeWord = rtValue;
                storeSel = 4'b1111;
            end
        endcase
    end

    assign cacheReq.valid = isLoad || isStore;
    assign cacheReq.we = isStore;
    assign cacheReq.addr = exStage.addr;
    assign cacheReq.wdata = storeWord;
    assign cacheReq.sel = storeSel;

    // wait until the cache answers
    assign memStall = cacheReq.valid && !cacheReady;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load data path and pipeline register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    loadAligner aligner (
        .op         (exStage.op),
        .offset     (offset),
        .rawData    (cacheRdata),
        .passData   (exStage.addr),
        .regWe      (exStage.regWe),
        .data       (alignedData),
        .regWeBytes (alignedWe)
    );

    // countdown stops at zero
    assign tNext = (exStage.t == 4'd0) ? 4'd0 : exStage.t - 4'd1;

    always_ff @(posedge Clk) begin
        if (!rstN || flush) begin
            memOut <= '0;
        end else if (!memStall) begin
            memOut.regWe <= exStage.regWe;
            memOut.regWeBytes <= alignedWe;
            memOut.regId <= exStage.regNum;
            memOut.data <= alignedData;
            memOut.pc <= exStage.pc;
            memOut.t <= tNext;
        end
    end

endmodule

// ==== dataCache/dataCache.sv ====
module dataCache (
    input  logic                   Clk,
    input  logic                   rstN,
    input  memStagePkg::cacheReqS  req,
    output logic                   ready,
    output logic [31:0]            rdata,
    output memStagePkg::busReqS    busReq,
    input  logic                   busDone,
    input  logic [31:0]            busRdata
);
    import memStagePkg::*;

    typedef enum logic [1:0] {
        sIdle,
        sWait,
        sDone
    } cacheStateE;

    cacheStateE state;
    // request that owns the bus
    cacheReqS pend;
    cacheReqS busSrc;

    logic [cacheLines-1:0] lineValid;
    logic [tagBits-1:0]    tagArr [cacheLines];
    logic [31:0]           dataArr [cacheLines];

    logic [indexBits-1:0] reqIdx;
    logic [indexBits-1:0] pendIdx;
    logic [tagBits-1:0]   reqTag;
    logic [tagBits-1:0]   pendTag;
    logic                 reqCached;
    logic                 pendCached;
    logic                 reqHit;
    logic                 pendHit;
    logic                 needBus;
    logic                 sameReq;
    logic [31:0]          mergedWord;

    assign reqIdx = req.addr[indexBits+1:2];
    assign pendIdx = pend.addr[indexBits+1:2];
    assign reqTag = req.addr[31:indexBits+2];
    assign pendTag = pend.addr[31:indexBits+2];

    assign reqCached = req.addr[31:29] != uncachedSeg;
    assign pendCached = pend.addr[31:29] != uncachedSeg;
    assign reqHit = lineValid[reqIdx] && tagArr[reqIdx] == reqTag;
    assign pendHit = lineValid[pendIdx] && tagArr[pendIdx] == pendTag;

    // stores always go through to memory
    assign needBus = req.valid && (req.we || !reqCached || !reqHit);
    // a flushed stage may present something else by the time data returns
    assign sameReq = req == pend;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus request, stable from pend while waiting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign busSrc = (state == sIdle) ? req : pend;

    assign busReq.valid = (state == sIdle) ? needBus : (state == sWait);
    assign busReq.we = busSrc.we;
    assign busReq.addr = busSrc.addr;
    assign busReq.wdata = busSrc.wdata;
    assign busReq.sel = busSrc.sel;

    always_comb begin
        unique case (state)
            sIdle: ready = req.valid && !needBus;
            sDone: ready = sameReq;
            default: ready = 1'b0;
        endcase
    end

    assign rdata = (state == sDone) ? busRdata : dataArr[reqIdx];

    // write-through byte merge into a hit line
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mergedWord[8*i +: 8] = pend.sel[i] ? pend.wdata[8*i +: 8]
                                               : dataArr[pendIdx][8*i +: 8];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and arrays
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= sIdle;
        end else begin
            unique case (state)
                sIdle: if (needBus) state <= sWait;
                sWait: if (busDone) state <= sDone;
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == sIdle && needBus) begin
            pend <= req;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            lineValid <= '0;
        end else if (state == sDone && pendCached && !pend.we) begin
            lineValid[pendIdx] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (state == sDone && pendCached) begin
            if (!pend.we) begin
                tagArr[pendIdx] <= pendTag;
                dataArr[pendIdx] <= busRdata;
            end else if (pendHit) begin
                dataArr[pendIdx] <= mergedWord;
            end
        end
    end

endmodule

// ==== src/wbMaster.sv ====
module wbMaster (
    input  logic                 Clk,
    input  logic                 rstN,
    input  memStagePkg::busReqS  busReq,
    output logic                 busDone,
    output logic [31:0]          busRdata,
    output memStagePkg::wbOutS   wbOut,
    input  memStagePkg::wbInS    wbIn
);
    import memStagePkg::*;

    typedef enum logic {
        mIdle,
        mActive
    } wbStateE;

    wbStateE state;

    // ack only counts inside our own cycle
    assign busDone = (state == mActive) && wbIn.ack;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= mIdle;
            wbOut.cyc <= 1'b0;
            wbOut.stb <= 1'b0;
        end else begin
            unique case (state)
                mIdle: begin
                    if (busReq.valid) begin
                        state <= mActive;
                        wbOut.cyc <= 1'b1;
                        wbOut.stb <= 1'b1;
                        wbOut.we <= busReq.we;
                        // word address, lanes picked by sel
                        wbOut.adr <= {busReq.addr[31:2], 2'b00};
                        wbOut.datW <= busReq.wdata;
                        wbOut.sel <= busReq.sel;
                    end
                end
                mActive: begin
                    if (wbIn.ack) begin
                        state <= mIdle;
                        wbOut.cyc <= 1'b0;
                        wbOut.stb <= 1'b0;
                    end
                end
                default: begin
                    state <= mIdle;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (busDone) begin
            busRdata <= wbIn.datR;
        end
    end

endmodule

// ==== src/memSubsystem.sv ====
module memSubsystem (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   flush,
    input  memStagePkg::exStageS   exStage,
    output memStagePkg::memStageS  memOut,
    output logic                   memStall,
    output memStagePkg::wbOutS     wbOut,
    input  memStagePkg::wbInS      wbIn
);
    import memStagePkg::*;

    cacheReqS    cacheReq;
    logic        cacheReady;
    logic [31:0] cacheRdata;
    busReqS      busReq;
    logic        busDone;
    logic [31:0] busRdata;

    memStage stage (
        .Clk        (Clk),
        .rstN       (rstN),
        .flush      (flush),
        .exStage    (exStage),
        .cacheReq   (cacheReq),
        .cacheReady (cacheReady),
        .cacheRdata (cacheRdata),
        .memStall   (memStall),
        .memOut     (memOut)
    );

    dataCache cache (
        .Clk      (Clk),
        .rstN     (rstN),
        .req      (cacheReq),
        .ready    (cacheReady),
        .rdata    (cacheRdata),
        .busReq   (busReq),
        .busDone  (busDone),
        .busRdata (busRdata)
    );

    wbMaster master (
        .Clk      (Clk),
        .rstN     (rstN),
        .busReq   (busReq),
        .busDone  (busDone),
        .busRdata (busRdata),
        .wbOut    (wbOut),
        .wbIn     (wbIn)
    );

endmodule

// ==== verif/clockGen.sv ====
module clockGen (
    output logic Clk,
    output logic rstN
);
    localparam int halfPeriod = 20;

    initial begin
        Clk = 1'b0;
        forever #halfPeriod Clk = ~Clk;
    end

    // low across the first two rising edges
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
    end

endmodule

// ==== verif/wbMemModel.sv ====
module wbMemModel (
    input  logic                Clk,
    input  logic                rstN,
    input  memStagePkg::wbOutS  wbOut,
    output memStagePkg::wbInS   wbIn,
    output int unsigned         busCycles
);
    import memStagePkg::*;

    localparam int memWords = 256;

    logic [31:0] mem [memWords];
    logic [7:0]  wordIdx;
    logic [1:0]  ackDelay = 2'd0;
    logic        ack = 1'b0;
    logic [31:0] datR = 32'd0;
    int unsigned cycleCount = 0;

    function automatic logic [31:0] fillWord(input logic [7:0] idx);
        return {idx ^ 8'hC3, idx ^ 8'h5A, idx ^ 8'h96, idx ^ 8'h21};
    endfunction

    initial begin
        void'($urandom(54));
        for (int w = 0; w < memWords; w++) begin
            mem[w] = fillWord(8'(w));
        end
    end

    assign wordIdx = wbOut.adr[9:2];
    assign wbIn.ack = ack;
    assign wbIn.datR = datR;
    assign busCycles = cycleCount;

    // one-cycle ack after 0 to 3 wait cycles
    always @(posedge Clk) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else if (ack) begin
            ack <= 1'b0;
            ackDelay <= 2'($urandom_range(3, 0));
        end else if (wbOut.cyc && wbOut.stb) begin
            if (ackDelay == 2'd0) begin
                ack <= 1'b1;
                cycleCount <= cycleCount + 1;
                if (wbOut.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wbOut.sel[b]) begin
                            mem[wordIdx][8*b +: 8] = wbOut.datW[8*b +: 8];
                        end
                    end
                end else begin
                    datR <= mem[wordIdx];
                end
            end else begin
                ackDelay <= ackDelay - 2'd1;
            end
        end
    end

endmodule

// ==== verif/memSubsystemTb.sv ====
module memSubsystemTb;
    import memStagePkg::*;

    localparam int stallLimit = 50;
    localparam int settle = 5;
    localparam int memWords = 256;
    localparam logic [31:0] cachedBase = 32'h0000_0040;
    localparam logic [31:0] uncachedBase = 32'hA000_0240;

    logic        Clk;
    logic        rstN;
    logic        flush;
    exStageS     exStage;
    memStageS    memOut;
    logic        memStall;
    wbOutS       wbOut;
    wbInS        wbIn;
    int unsigned busCycles;

    // one row per instruction in issue order
    exStageS     stimQ[$];
    logic        flushQ[$];
    memStageS    expQ[$];
    int unsigned busQ[$];

    // reference memory, cache presence and last stage result
    logic [31:0] refMem [memWords];
    logic [63:0] refValid;
    logic [23:0] refTag [64];
    memStageS    lastOut;
    logic [31:0] nextPc;

    int mismatches;
    int timeouts;

    clockGen clocks (
        .Clk  (Clk),
        .rstN (rstN)
    );

    memSubsystem UUT (
        .Clk      (Clk),
        .rstN     (rstN),
        .flush    (flush),
        .exStage  (exStage),
        .memOut   (memOut),
        .memStall (memStall),
        .wbOut    (wbOut),
        .wbIn     (wbIn)
    );

    wbMemModel memory (
        .Clk       (Clk),
        .rstN      (rstN),
        .wbOut     (wbOut),
        .wbIn      (wbIn),
        .busCycles (busCycles)
    );

    // same fill as the bus memory model
    function automatic logic [31:0] initialWord(input logic [7:0] idx);
        return {idx ^ 8'hC3, idx ^ 8'h5A, idx ^ 8'h96, idx ^ 8'h21};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model that builds one table row per call
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic appendRow(input memOpE op, input logic [31:0] addr,
                             input logic [31:0] rtData, input logic [4:0] rtId,
                             input logic regWe, input logic [4:0] regNum,
                             input logic [3:0] t, input logic doFlush);
        exStageS     ex;
        memStageS    want;
        logic [31:0] word;
        logic [31:0] rt;
        logic [7:0]  idx;
        logic [5:0]  line;
        logic        cached;
        int          o;
        int          src;
        int unsigned bus;

        ex = '{pc: nextPc, op: op, addr: addr, storeData: rtData, rtId: rtId,
               regWe: regWe, regNum: regNum, t: t};
        nextPc = nextPc + 32'd4;
        idx = addr[9:2];
        line = addr[7:2];
        o = int'(addr[1:0]);
        cached = addr[31:29] != 3'b101;
        bus = 0;
        rt = rtData;
        if (lastOut.regWe && rtId != 5'd0 && rtId == lastOut.regId) begin
            rt = lastOut.data;
        end

        if (op inside {opLb, opLbu, opLh, opLhu, opLw, opLwl, opLwr}) begin
            if (!cached || !(refValid[line] && refTag[line] == addr[31:8])) begin
                bus = 1;
            end
            if (cached) begin
                refValid[line] = 1'b1;
                refTag[line] = addr[31:8];
            end
        end

        // every store reaches memory byte by byte
        if (op inside {opSb, opSh, opSw, opSwl}) begin
            bus = 1;
            for (int k = 0; k < 4; k++) begin
                src = -1;
                case (op)
                    opSb: if (k == o) src = 0;
                    opSh: if (k == o || k == o + 1) src = k - o;
                    opSw: src = k;
                    default: if (k <= o) src = k + 3 - o;
                endcase
                if (src >= 0) begin
                    refMem[idx][8*k +: 8] = rt[8*src +: 8];
                end
            end
        end

        word = refMem[idx];
        want = '0;
        want.regWe = regWe;
        want.regId = regNum;
        want.pc = ex.pc;
        if (t != 4'd0) begin
            want.t = t - 4'd1;
        end
        want.data = addr;
        want.regWeBytes = {4{regWe}};
        case (op)
            opLb: want.data = {{24{word[8*o+7]}}, word[8*o +: 8]};
            opLbu: want.data = {24'd0, word[8*o +: 8]};
            opLh: want.data = {{16{word[8*o+15]}}, word[8*o +: 16]};
            opLhu: want.data = {16'd0, word[8*o +: 16]};
            opLw: want.data = word;
            opLwl: begin
                want.data = word << (8 * o);
                want.regWeBytes = {4{regWe}} & (4'b1111 << (3 - o));
            end
            opLwr: begin
                want.data = word >> (8 * o);
                want.regWeBytes = {4{regWe}} & (4'b1111 >> o);
            end
            default: ;
        endcase
        if (doFlush) begin
            want = '0;
        end
        lastOut = want;

        stimQ.push_back(ex);
        flushQ.push_back(doFlush);
        expQ.push_back(want);
        busQ.push_back(bus);
    endtask

    task automatic loadRow(input memOpE op, input logic [31:0] addr, input logic [4:0] regNum);
        appendRow(op, addr, 32'd0, 5'd0, 1'b1, regNum, 4'd3, 1'b0);
    endtask

    task automatic storeRow(input memOpE op, input logic [31:0] addr, input logic [31:0] rtData);
        appendRow(op, addr, rtData, 5'd0, 1'b0, 5'd0, 4'd1, 1'b0);
    endtask

    task automatic buildTable();
        logic [31:0] base;

        // pass-through data and a countdown that saturates at zero
        appendRow(opNone, 32'h1234_5678, 32'd0, 5'd0, 1'b1, 5'd3, 4'd2, 1'b0);
        appendRow(opNone, 32'h8765_4321, 32'd0, 5'd0, 1'b1, 5'd4, 4'd1, 1'b0);
        appendRow(opNone, 32'hDEAD_BEEF, 32'd0, 5'd0, 1'b1, 5'd5, 4'd0, 1'b0);
        appendRow(opNone, 32'h0BAD_F00D, 32'd0, 5'd0, 1'b0, 5'd6, 4'd9, 1'b0);

        for (int s = 0; s < 2; s++) begin
            base = (s == 0) ? cachedBase : uncachedBase;
            for (int o = 0; o < 4; o++) begin
                loadRow(opLb, base + 32'(o), 5'(o + 8));
                loadRow(opLbu, base + 32'(o), 5'(o + 8));
                if (o % 2 == 0) begin
                    loadRow(opLh, base + 32'(o), 5'(o + 8));
                    loadRow(opLhu, base + 32'(o), 5'(o + 8));
                end
                loadRow(opLwl, base + 32'(o), 5'(o + 8));
                loadRow(opLwr, base + 32'(o), 5'(o + 8));
            end
            loadRow(opLw, base, 5'd12);
        end
        appendRow(opLwl, cachedBase + 32'd2, 32'd0, 5'd0, 1'b0, 5'd9, 4'd1, 1'b0);

        // same line index with another tag
        loadRow(opLw, 32'h0000_0140, 5'd10);
        loadRow(opLw, cachedBase, 5'd11);

        storeRow(opSw, cachedBase, 32'h1122_3344);
        loadRow(opLw, cachedBase, 5'd12);
        storeRow(opSb, cachedBase + 32'd1, 32'h0000_00AB);
        loadRow(opLw, cachedBase, 5'd12);
        storeRow(opSh, cachedBase + 32'd2, 32'h0000_BEEF);
        loadRow(opLw, cachedBase, 5'd12);
        for (int o = 0; o < 4; o++) begin
            storeRow(opSwl, cachedBase + 32'(o), 32'hCAFE_F00D);
            loadRow(opLw, cachedBase, 5'd13);
        end
        storeRow(opSh, uncachedBase + 32'd2, 32'h0000_7E57);
        loadRow(opLh, uncachedBase + 32'd2, 5'd14);
        // no write-allocate on a store miss
        storeRow(opSw, 32'h0000_0080, 32'h5555_AAAA);
        loadRow(opLw, 32'h0000_0080, 5'd15);
        loadRow(opLw, 32'h0000_0080, 5'd15);

        // store data taken from the previous load
        loadRow(opLw, uncachedBase, 5'd16);
        appendRow(opSw, 32'h0000_00C0, 32'hFFFF_FFFF, 5'd16, 1'b0, 5'd0, 4'd1, 1'b0);
        loadRow(opLw, 32'h0000_00C0, 5'd17);

        appendRow(opNone, 32'h7777_0000, 32'd0, 5'd0, 1'b1, 5'd18, 4'd5, 1'b1);
        appendRow(opLw, cachedBase, 32'd0, 5'd0, 1'b1, 5'd19, 4'd5, 1'b1);
        // flushed result must not forward
        appendRow(opSw, 32'h0000_00C4, 32'h1357_9BDF, 5'd19, 1'b0, 5'd0, 4'd1, 1'b0);
        loadRow(opLw, 32'h0000_00C4, 5'd20);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reportMismatch(input int i, input string field,
                                  input logic [31:0] got, input logic [31:0] want);
        $display("FAILED at time %0t: entry %0d %s is %h, expected %h",
                 $time, i, field, got, want);
        mismatches++;
    endtask

    task automatic checkEntry(input int i, input int unsigned busDelta);
        memStageS want;

        want = expQ[i];
        if (memOut.regWe !== want.regWe) begin
            reportMismatch(i, "regWe", 32'(memOut.regWe), 32'(want.regWe));
        end
        if (memOut.regWeBytes !== want.regWeBytes) begin
            reportMismatch(i, "regWeBytes", 32'(memOut.regWeBytes), 32'(want.regWeBytes));
        end
        if (memOut.regId !== want.regId) begin
            reportMismatch(i, "regId", 32'(memOut.regId), 32'(want.regId));
        end
        if (memOut.data !== want.data) begin
            reportMismatch(i, "data", memOut.data, want.data);
        end
        if (memOut.pc !== want.pc) begin
            reportMismatch(i, "pc", memOut.pc, want.pc);
        end
        if (memOut.t !== want.t) begin
            reportMismatch(i, "t", 32'(memOut.t), 32'(want.t));
        end
        if (busDelta != busQ[i]) begin
            reportMismatch(i, "bus cycle count", busDelta, busQ[i]);
        end
    endtask

    initial begin
        int          waitCount;
        int unsigned busBefore;

        flush = 1'b0;
        exStage = '0;
        mismatches = 0;
        timeouts = 0;
        lastOut = '0;
        nextPc = 32'h0040_0000;
        refValid = '0;
        for (int w = 0; w < memWords; w++) begin
            refMem[w] = initialWord(8'(w));
        end
        buildTable();

        waitCount = 0;
        while (!rstN && waitCount < stallLimit) begin
            @(negedge Clk);
            waitCount++;
        end
        if (!rstN) begin
            $display("reset was never released");
            timeouts++;
        end else begin
            if (memOut !== '0) begin
                $display("FAILED at time %0t: memOut %h not zero after reset", $time, memOut);
                mismatches++;
            end
            if (wbOut.cyc !== 1'b0) begin
                $display("FAILED at time %0t: cyc high after reset", $time);
                mismatches++;
            end
            if (wbOut.stb !== 1'b0) begin
                $display("FAILED at time %0t: stb high after reset", $time);
                mismatches++;
            end

            // each pass starts on a falling edge
            for (int i = 0; i < stimQ.size(); i++) begin
                busBefore = busCycles;
                flush = flushQ[i];
                exStage = stimQ[i];
                #settle;
                // a miss, an uncached access or a store has to wait for the bus
                if (memStall !== (busQ[i] != 0)) begin
                    reportMismatch(i, "memStall", 32'(memStall), 32'(busQ[i] != 0));
                end
                waitCount = 0;
                while (memStall && waitCount < stallLimit) begin
                    @(negedge Clk);
                    waitCount++;
                end
                if (memStall) begin
                    $display("stall never released for entry %0d at time %0t", i, $time);
                    timeouts++;
                    break;
                end
                @(posedge Clk);
                @(negedge Clk);
                checkEntry(i, busCycles - busBefore);
            end
            flush = 1'b0;
            exStage = '0;
        end

        $display("Summary: %0d entries, %0d mismatches, %0d timeouts",
                 stimQ.size(), mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
common/memStagePkg.sv
memStage/loadAligner.sv
memStage/memStage.sv
dataCache/dataCache.sv
src/wbMaster.sv
src/memSubsystem.sv
verif/clockGen.sv
verif/wbMemModel.sv
verif/memSubsystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --top-module memSubsystemTb -f list.f -Mdir obj_dir -o simMemSubsystem
./obj_dir/simMemSubsystem | tee sim.log

if grep -qx "Verification passed" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi
